// ==== design/tcdm_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// TCDM shared definitions
// word, byte-enable and address sizes plus the byte offset
// below the bank index in an initiator address
// ~~~~~~~~~~~~~~~~~~~~

package tcdm_pkg;

  // data word
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;  // one enable per byte

  // byte address as seen by an initiator
  localparam int unsigned AddrWidth = 32;

  // word-interleaved layout from the lsb up
  //   [ByteOffBits-1:0]  byte within the word that the banks ignore
  //   next log2(NbBanks) bank index
  //   next log2(BankSize) row inside the bank
  localparam int unsigned ByteOffBits = 2;

  typedef logic [DataWidth-1:0] data_t;  // one data word
  typedef logic [BeWidth-1:0]   be_t;    // byte enables of one word
  typedef logic [AddrWidth-1:0] addr_t;  // byte address

endpackage : tcdm_pkg

// ==== design/tcdm_sram_bank.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// TCDM SRAM bank
// single port, byte-enable writes, one cycle read latency
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tcdm_sram_bank #(
  parameter int unsigned BankSize = 64  // words, power of two
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,    // access this cycle
  input  logic                        we_i,     // active high write
  input  logic [$clog2(BankSize)-1:0] addr_i,   // row index
  input  tcdm_pkg::data_t             wdata_i,
  input  tcdm_pkg::be_t               be_i,
  output tcdm_pkg::data_t             rdata_o   // valid the cycle after a read
);

  // storage starts as all ones
  tcdm_pkg::data_t mem_q [BankSize] = '{default: '1};
  tcdm_pkg::data_t rdata_q;

  // write port touches only the enabled bytes
  always_ff @(posedge clk_i) begin : mem_write
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < tcdm_pkg::BeWidth; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // read port register holds the last word read
  always_ff @(posedge clk_i) begin : mem_read
    if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

  // every access needs a defined row and direction
  a_access_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_i |-> !$isunknown({we_i, addr_i})
  ) else $error("bank access with unknown row %0d or write enable %b", addr_i, we_i);

endmodule : tcdm_sram_bank

// ==== design/tcdm_bank_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// TCDM bank arbiter
// round-robin choice of one initiator for one bank
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tcdm_bank_arbiter #(
  parameter int unsigned NbPorts = 2,
  localparam int unsigned IdWidth = (NbPorts > 1) ? $clog2(NbPorts) : 1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [NbPorts-1:0] req_i,   // initiators aiming at this bank
  output logic [NbPorts-1:0] gnt_o,   // one-hot winner, zero when idle
  output logic [IdWidth-1:0] idx_o    // winner index
);

  logic [IdWidth-1:0] ptr_q;     // highest priority initiator this cycle
  logic [IdWidth-1:0] ptr_d;
  logic [IdWidth-1:0] win_idx;
  logic               win_found;

  // scan from the pointer, wrapping around, first requester wins
  always_comb begin : pick_winner
    int unsigned cand;
    win_found = 1'b0;
    win_idx   = '0;
    for (int unsigned k = 0; k < NbPorts; k++) begin
      cand = (int'(ptr_q) + k) % NbPorts;
      if (!win_found && req_i[cand]) begin
        win_found = 1'b1;
        win_idx   = IdWidth'(cand);
      end
    end
  end

  always_comb begin : drive_gnt
    gnt_o = '0;
    if (win_found) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  assign idx_o = win_idx;

  // next priority goes to the one after the winner
  always_comb begin : next_ptr
    ptr_d = ptr_q;
    if (win_found) begin
      if (win_idx == IdWidth'(NbPorts - 1)) begin
        ptr_d = '0;                       // wrap
      end else begin
        ptr_d = win_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : ptr_reg
    if (!rst_ni) begin
      ptr_q <= '0;
    end else begin
      ptr_q <= ptr_d;
    end
  end

  // single winner, and only someone who asked
  a_gnt_legal : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0)
  ) else $error("illegal grant vector %b for requests %b", gnt_o, req_i);

endmodule : tcdm_bank_arbiter

// ==== design/tcdm_banks_wrap.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// TCDM bank array
// NbBanks SRAM banks, always granting, with registered
// response id and r_valid for reads
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tcdm_banks_wrap #(
  parameter int unsigned NbBanks  = 4,
  parameter int unsigned BankSize = 64,
  parameter int unsigned NbPorts  = 2,
  localparam int unsigned RowWidth = $clog2(BankSize),
  localparam int unsigned IdWidth  = (NbPorts > 1) ? $clog2(NbPorts) : 1
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // request side with one entry per bank
  input  logic            [NbBanks-1:0]                bank_req_i,
  input  logic            [NbBanks-1:0][RowWidth-1:0]  bank_add_i,   // row address
  input  logic            [NbBanks-1:0]                bank_wen_i,   // low = write
  input  tcdm_pkg::data_t [NbBanks-1:0]                bank_data_i,
  input  tcdm_pkg::be_t   [NbBanks-1:0]                bank_be_i,
  input  logic            [NbBanks-1:0][IdWidth-1:0]   bank_id_i,    // winning initiator
  output logic            [NbBanks-1:0]                bank_gnt_o,
  // response side
  output logic            [NbBanks-1:0]                bank_r_valid_o,
  output tcdm_pkg::data_t [NbBanks-1:0]                bank_r_data_o,
  output logic            [NbBanks-1:0][IdWidth-1:0]   bank_r_id_o
);

  for (genvar i = 0; i < NbBanks; i++) begin : gen_banks

    logic               r_valid_q;
    logic [IdWidth-1:0] r_id_q;

    // a bank serves one access per cycle and never stalls
    assign bank_gnt_o[i] = 1'b1;

    // id follows the data through the one cycle pipeline
    always_ff @(posedge clk_i or negedge rst_ni) begin : resp_id
      if (!rst_ni) begin
        r_id_q <= '0;
      end else begin
        r_id_q <= bank_id_i[i];
      end
    end

    // only a granted read answers while writes stay silent
    always_ff @(posedge clk_i or negedge rst_ni) begin : resp_valid
      if (!rst_ni) begin
        r_valid_q <= 1'b0;
      end else begin
        r_valid_q <= bank_req_i[i] && bank_gnt_o[i] && bank_wen_i[i];
      end
    end

    assign bank_r_valid_o[i] = r_valid_q;
    assign bank_r_id_o[i]    = r_id_q;

    tcdm_sram_bank #(
      .BankSize (BankSize)
    ) u_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (bank_req_i[i]),
      .we_i    (~bank_wen_i[i]),      // sram wants active high write
      .addr_i  (bank_add_i[i]),
      .wdata_i (bank_data_i[i]),
      .be_i    (bank_be_i[i]),
      .rdata_o (bank_r_data_o[i])
    );

    // sram output must line up with r_valid and carry a defined word
    a_resp_data_known : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      bank_r_valid_o[i] |-> !$isunknown(bank_r_data_o[i])
    ) else $error("bank %0d raised r_valid with undefined read data", i);

  end

endmodule : tcdm_banks_wrap

// ==== design/tcdm_interconnect.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// TCDM interconnect
// decodes initiator addresses, arbitrates each bank and
// routes read responses back by id
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tcdm_interconnect #(
  parameter int unsigned NbPorts  = 2,
  parameter int unsigned NbBanks  = 4,
  parameter int unsigned BankSize = 64,
  localparam int unsigned BankIdxW = $clog2(NbBanks),
  localparam int unsigned RowWidth = $clog2(BankSize),
  localparam int unsigned IdWidth  = (NbPorts > 1) ? $clog2(NbPorts) : 1
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // initiator side
  input  logic            [NbPorts-1:0]                req_i,
  input  tcdm_pkg::addr_t [NbPorts-1:0]                add_i,
  input  logic            [NbPorts-1:0]                wen_i,      // low = write
  input  tcdm_pkg::data_t [NbPorts-1:0]                data_i,
  input  tcdm_pkg::be_t   [NbPorts-1:0]                be_i,
  output logic            [NbPorts-1:0]                gnt_o,
  output logic            [NbPorts-1:0]                r_valid_o,
  output tcdm_pkg::data_t [NbPorts-1:0]                r_data_o,
  // bank side
  output logic            [NbBanks-1:0]                bank_req_o,
  output logic            [NbBanks-1:0][RowWidth-1:0]  bank_add_o,
  output logic            [NbBanks-1:0]                bank_wen_o,
  output tcdm_pkg::data_t [NbBanks-1:0]                bank_data_o,
  output tcdm_pkg::be_t   [NbBanks-1:0]                bank_be_o,
  output logic            [NbBanks-1:0][IdWidth-1:0]   bank_id_o,
  input  logic            [NbBanks-1:0]                bank_gnt_i,
  input  logic            [NbBanks-1:0]                bank_r_valid_i,
  input  tcdm_pkg::data_t [NbBanks-1:0]                bank_r_data_i,
  input  logic            [NbBanks-1:0][IdWidth-1:0]   bank_r_id_i
);

  logic [NbPorts-1:0][BankIdxW-1:0] port_bank;       // target bank per initiator
  logic [NbPorts-1:0][RowWidth-1:0] port_row;        // row inside that bank
  logic [NbBanks-1:0][NbPorts-1:0]  bank_port_req;   // who wants each bank
  logic [NbBanks-1:0][NbPorts-1:0]  bank_port_gnt;   // arbiter winner per bank
  logic [NbBanks-1:0][IdWidth-1:0]  win_idx;
  logic [NbPorts-1:0][NbBanks-1:0]  resp_hit;        // bank b answers port p

  // fixed field split, bits above the row are dropped
  for (genvar p = 0; p < NbPorts; p++) begin : gen_decode
    assign port_bank[p] = add_i[p][tcdm_pkg::ByteOffBits +: BankIdxW];
    assign port_row[p]  = add_i[p][tcdm_pkg::ByteOffBits + BankIdxW +: RowWidth];
  end

  for (genvar b = 0; b < NbBanks; b++) begin : gen_bank

    for (genvar p = 0; p < NbPorts; p++) begin : gen_req_vec
      assign bank_port_req[b][p] = req_i[p] && (port_bank[p] == BankIdxW'(b));
    end

    tcdm_bank_arbiter #(
      .NbPorts (NbPorts)
    ) u_arbiter (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .req_i  (bank_port_req[b]),
      .gnt_o  (bank_port_gnt[b]),
      .idx_o  (win_idx[b])
    );

    // winner's request goes through, index rides along as id
    assign bank_req_o[b]  = |bank_port_req[b];
    assign bank_add_o[b]  = port_row[win_idx[b]];
    assign bank_wen_o[b]  = wen_i[win_idx[b]];
    assign bank_data_o[b] = data_i[win_idx[b]];
    assign bank_be_o[b]   = be_i[win_idx[b]];
    assign bank_id_o[b]   = win_idx[b];
  end

  // gnt needs both the arbiter win and the bank accepting
  always_comb begin : route_gnt
    gnt_o = '0;
    for (int unsigned b = 0; b < NbBanks; b++) begin
      for (int unsigned p = 0; p < NbPorts; p++) begin
        if (bank_port_gnt[b][p] && bank_gnt_i[b]) begin
          gnt_o[p] = 1'b1;
        end
      end
    end
  end

  // response goes to whoever the id names
  always_comb begin : route_resp
    resp_hit  = '0;
    r_valid_o = '0;
    r_data_o  = '0;
    for (int unsigned b = 0; b < NbBanks; b++) begin
      for (int unsigned p = 0; p < NbPorts; p++) begin
        if (bank_r_valid_i[b] && (bank_r_id_i[b] == IdWidth'(p))) begin
          resp_hit[p][b] = 1'b1;
          r_valid_o[p]   = 1'b1;
          r_data_o[p]    = bank_r_data_i[b];
        end
      end
    end
  end

  // an initiator gets one grant per cycle so at most one bank answers it
  for (genvar p = 0; p < NbPorts; p++) begin : gen_resp_chk
    a_single_resp : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      $onehot0(resp_hit[p])
    ) else $error("port %0d got responses from several banks: %b", p, resp_hit[p]);
  end

endmodule : tcdm_interconnect

// ==== design/tcdm_subsystem.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// TCDM subsystem top
// interconnect plus word-interleaved bank array
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tcdm_subsystem #(
  parameter int unsigned NbPorts  = 2,   // initiators
  parameter int unsigned NbBanks  = 4,   // power of two
  parameter int unsigned BankSize = 64,  // words per bank, power of two
  localparam int unsigned RowWidth = $clog2(BankSize),
  localparam int unsigned IdWidth  = (NbPorts > 1) ? $clog2(NbPorts) : 1
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic            [NbPorts-1:0]   req_i,
  input  tcdm_pkg::addr_t [NbPorts-1:0]   add_i,     // byte address
  input  logic            [NbPorts-1:0]   wen_i,     // low = write
  input  tcdm_pkg::data_t [NbPorts-1:0]   data_i,
  input  tcdm_pkg::be_t   [NbPorts-1:0]   be_i,
  output logic            [NbPorts-1:0]   gnt_o,
  output logic            [NbPorts-1:0]   r_valid_o, // one cycle after a read grant
  output tcdm_pkg::data_t [NbPorts-1:0]   r_data_o
);

  // interconnect to banks
  logic            [NbBanks-1:0]               bank_req;
  logic            [NbBanks-1:0][RowWidth-1:0] bank_add;
  logic            [NbBanks-1:0]               bank_wen;
  tcdm_pkg::data_t [NbBanks-1:0]               bank_data;
  tcdm_pkg::be_t   [NbBanks-1:0]               bank_be;
  logic            [NbBanks-1:0][IdWidth-1:0]  bank_id;
  // banks back to interconnect
  logic            [NbBanks-1:0]               bank_gnt;
  logic            [NbBanks-1:0]               bank_r_valid;
  tcdm_pkg::data_t [NbBanks-1:0]               bank_r_data;
  logic            [NbBanks-1:0][IdWidth-1:0]  bank_r_id;

  tcdm_interconnect #(
    .NbPorts  (NbPorts),
    .NbBanks  (NbBanks),
    .BankSize (BankSize)
  ) u_interconnect (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .add_i          (add_i),
    .wen_i          (wen_i),
    .data_i         (data_i),
    .be_i           (be_i),
    .gnt_o          (gnt_o),
    .r_valid_o      (r_valid_o),
    .r_data_o       (r_data_o),
    .bank_req_o     (bank_req),
    .bank_add_o     (bank_add),
    .bank_wen_o     (bank_wen),
    .bank_data_o    (bank_data),
    .bank_be_o      (bank_be),
    .bank_id_o      (bank_id),
    .bank_gnt_i     (bank_gnt),
    .bank_r_valid_i (bank_r_valid),
    .bank_r_data_i  (bank_r_data),
    .bank_r_id_i    (bank_r_id)
  );

  tcdm_banks_wrap #(
    .NbBanks  (NbBanks),
    .BankSize (BankSize),
    .NbPorts  (NbPorts)
  ) u_banks (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .bank_req_i     (bank_req),
    .bank_add_i     (bank_add),
    .bank_wen_i     (bank_wen),
    .bank_data_i    (bank_data),
    .bank_be_i      (bank_be),
    .bank_id_i      (bank_id),
    .bank_gnt_o     (bank_gnt),
    .bank_r_valid_o (bank_r_valid),
    .bank_r_data_o  (bank_r_data),
    .bank_r_id_o    (bank_r_id)
  );

endmodule : tcdm_subsystem

// ==== verification/tb_tcdm_subsystem.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// TCDM subsystem testbench
// file driven initiators, reference memory and round-robin model
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_tcdm_subsystem;

  localparam int unsigned NbPorts  = 2;
  localparam int unsigned NbBanks  = 4;
  localparam int unsigned BankSize = 64;
  localparam int unsigned MaxOps   = 64;  // stimulus table depth

  logic                          clk_i = 1'b0;
  logic                          rst_ni;
  logic            [NbPorts-1:0] req_i;
  tcdm_pkg::addr_t [NbPorts-1:0] add_i;
  logic            [NbPorts-1:0] wen_i;   // low = write
  tcdm_pkg::data_t [NbPorts-1:0] data_i;
  tcdm_pkg::be_t   [NbPorts-1:0] be_i;
  logic            [NbPorts-1:0] gnt_o;
  logic            [NbPorts-1:0] r_valid_o;
  tcdm_pkg::data_t [NbPorts-1:0] r_data_o;

  // one entry per stimulus line
  int unsigned     op_phase [MaxOps];
  int unsigned     op_port  [MaxOps];
  logic            op_write [MaxOps];
  tcdm_pkg::addr_t op_addr  [MaxOps];
  tcdm_pkg::data_t op_data  [MaxOps];
  tcdm_pkg::be_t   op_be    [MaxOps];
  int unsigned     op_gap   [MaxOps];   // max idle cycles before the op
  tcdm_pkg::data_t op_exp   [MaxOps];
  int unsigned     nb_ops;
  int unsigned     nb_phases;

  tcdm_pkg::data_t    ref_mem [NbBanks*BankSize];  // word-indexed model of all banks
  tcdm_pkg::data_t    exp_q   [NbPorts][$];        // expected words in issue order
  tcdm_pkg::data_t    cur_exp [NbPorts];           // file expectation of the op on each port
  logic [NbPorts-1:0] rd_pend;                     // read granted in the previous cycle
  int unsigned        rr_ptr  [NbBanks];           // model of the arbiter pointers
  int unsigned        cycles;
  int unsigned        cycle_limit;

  tcdm_subsystem #(
    .NbPorts  (NbPorts),
    .NbBanks  (NbBanks),
    .BankSize (BankSize)
  ) u_tcdm_subsystem (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .add_i     (add_i),
    .wen_i     (wen_i),
    .data_i    (data_i),
    .be_i      (be_i),
    .gnt_o     (gnt_o),
    .r_valid_o (r_valid_o),
    .r_data_o  (r_data_o)
  );

  always #4 clk_i = ~clk_i;  // 8 ns period

  always @(posedge clk_i) begin : watchdog
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      abort_run("timeout: operations did not complete");
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_data(input tcdm_pkg::data_t got, input tcdm_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // word position in the interleaved space, high bits wrap away
  function automatic int unsigned word_idx(input tcdm_pkg::addr_t a);
    return (a >> tcdm_pkg::ByteOffBits) % (NbBanks * BankSize);
  endfunction

  task automatic load_stimulus();
    int    fd;
    int    n;
    string line;
    byte   opc;
    fd = $fopen("verification/tcdm_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open stimulus file verification/tcdm_stimulus.txt");
    end
    nb_ops    = 0;
    nb_phases = 0;
    while (!$feof(fd) && nb_ops < MaxOps) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == "#") continue;  // comment or end of file
      n = $sscanf(line, "%d %d %c %h %h %h %d %h", op_phase[nb_ops], op_port[nb_ops],
                  opc, op_addr[nb_ops], op_data[nb_ops], op_be[nb_ops],
                  op_gap[nb_ops], op_exp[nb_ops]);
      if (n == 8) begin
        op_write[nb_ops] = (opc == "W");
        if (op_phase[nb_ops] + 1 > nb_phases) nb_phases = op_phase[nb_ops] + 1;
        nb_ops++;
      end
    end
    $fclose(fd);
  endtask

  // plays the ops of one port in one phase, each held until granted
  task automatic run_port(input int unsigned p, input int unsigned ph);
    logic granted;
    for (int unsigned i = 0; i < nb_ops; i++) begin
      if (op_phase[i] != ph || op_port[i] != p) continue;
      req_i[p] = 1'b0;
      repeat ($urandom_range(op_gap[i], 0)) begin
        @(posedge clk_i);
        #1;
      end
      req_i[p]   = 1'b1;
      add_i[p]   = op_addr[i];
      wen_i[p]   = !op_write[i];
      data_i[p]  = op_data[i];
      be_i[p]    = op_be[i];
      cur_exp[p] = op_exp[i];
      granted    = 1'b0;
      while (!granted) begin
        @(negedge clk_i);
        granted = gnt_o[p];  // taken at the coming edge
        @(posedge clk_i);
        #1;
      end
    end
    req_i[p] = 1'b0;
  endtask

  // mid-cycle sampling, inputs and flops are both settled here
  always @(negedge clk_i) begin : monitor
    logic [NbPorts-1:0] exp_gnt;
    int unsigned        cand;
    int unsigned        w;
    if (!rst_ni) begin
      rd_pend = '0;
      for (int unsigned b = 0; b < NbBanks; b++) rr_ptr[b] = 0;
    end else begin
      for (int unsigned p = 0; p < NbPorts; p++) begin
        check_flag(r_valid_o[p], rd_pend[p], $sformatf("r_valid on port %0d", p));
        if (r_valid_o[p]) begin
          check_data(r_data_o[p], exp_q[p].pop_front(), $sformatf("read data port %0d", p));
        end
      end
      exp_gnt = '0;
      for (int unsigned b = 0; b < NbBanks; b++) begin
        cand = NbPorts;  // none yet
        for (int unsigned k = 0; k < NbPorts; k++) begin
          w = (rr_ptr[b] + k) % NbPorts;
          if (cand == NbPorts && req_i[w] && word_idx(add_i[w]) % NbBanks == b) cand = w;
        end
        if (cand != NbPorts) begin
          exp_gnt[cand] = 1'b1;
          rr_ptr[b]     = (cand + 1) % NbPorts;  // winner drops to lowest priority
        end
      end
      for (int unsigned p = 0; p < NbPorts; p++) begin
        check_flag(gnt_o[p], exp_gnt[p], $sformatf("gnt on port %0d", p));
        rd_pend[p] = exp_gnt[p] && wen_i[p];
        w = word_idx(add_i[p]);
        if (exp_gnt[p] && wen_i[p]) begin
          check_data(ref_mem[w], cur_exp[p], $sformatf("stimulus word port %0d", p));
          exp_q[p].push_back(ref_mem[w]);
        end else if (exp_gnt[p]) begin
          for (int unsigned j = 0; j < tcdm_pkg::BeWidth; j++) begin
            if (be_i[p][j]) ref_mem[w][8*j +: 8] = data_i[p][8*j +: 8];
          end
        end
      end
    end
  end

  initial begin : main
    int unsigned left;
    void'($urandom(32'h59dfd8ec));
    req_i       = '0;
    add_i       = '0;
    wen_i       = '1;
    data_i      = '0;
    be_i        = '0;
    rst_ni      = 1'b0;
    cycles      = 0;
    cycle_limit = 0;
    for (int unsigned i = 0; i < NbBanks * BankSize; i++) ref_mem[i] = '1;
    load_stimulus();
    cycle_limit = 20 * nb_ops + 50;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // phases start both ports on the same cycle
    for (int unsigned ph = 0; ph < nb_phases; ph++) begin
      @(posedge clk_i);
      #1;
      fork
        run_port(0, ph);
        run_port(1, ph);
      join
      repeat (2) @(posedge clk_i);  // last read answers
    end
    left = 0;
    for (int unsigned p = 0; p < NbPorts; p++) left += exp_q[p].size();
    if (left != 0) begin
      abort_run("granted reads never returned a response");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule : tb_tcdm_subsystem

// ==== verification/tcdm_stimulus.txt ====
# phase port op(R/W) byte_addr data be max_gap expected_read_word
# phases run in order, both ports start a phase together, write lines carry 0 as expected
0 0 R 00000040 00000000 0 0 ffffffff
0 1 R 00000084 00000000 0 0 ffffffff
1 0 W 00000000 12345678 f 0 00000000
1 0 R 00000000 00000000 0 2 12345678
1 1 W 00000104 cafef00d f 0 00000000
1 1 R 00000104 00000000 0 2 cafef00d
2 0 W 00000008 a5a5a5a5 f 1 00000000
2 0 W 00000008 00112233 5 2 00000000
2 0 R 00000008 00000000 0 1 a511a533
2 1 W 0000020c deadbeef 3 1 00000000
2 1 R 0000020c 00000000 0 2 ffffbeef
2 1 W 0000020c 77665544 c 1 00000000
2 1 R 0000020c 00000000 0 0 7766beef
3 0 R 00000000 00000000 0 0 12345678
3 0 W 00000030 0a0a0a0a f 0 00000000
3 0 R 00000030 00000000 0 1 0a0a0a0a
3 1 R 00000100 00000000 0 0 ffffffff
3 1 W 00000050 0b0b0b0b f 0 00000000
3 1 R 00000050 00000000 0 1 0b0b0b0b
4 0 R 00000104 00000000 0 0 cafef00d
4 0 R 0000020c 00000000 0 0 7766beef
4 1 R 00000008 00000000 0 0 a511a533
4 1 R 00000000 00000000 0 0 12345678
5 0 R 00000000 00000000 0 0 12345678
5 0 R 00000104 00000000 0 0 cafef00d
5 0 R 00000008 00000000 0 0 a511a533
5 0 R 0000020c 00000000 0 0 7766beef
5 0 R 00000040 00000000 0 0 ffffffff
5 1 W 000003fc 13572468 f 1 00000000
5 1 R 000003fc 00000000 0 0 13572468
5 1 R 00000400 00000000 0 0 12345678

// ==== tcdm_subsystem.f ====
design/tcdm_pkg.sv
design/tcdm_sram_bank.sv
design/tcdm_bank_arbiter.sv
design/tcdm_banks_wrap.sv
design/tcdm_interconnect.sv
design/tcdm_subsystem.sv
verification/tb_tcdm_subsystem.sv
